//--- hw/rv_alu_pkg.sv
// --------------------
// rv alu package
// opcodes, alu operation codes and the
// r/i instruction format views shared by
// the execution pipeline
// --------------------

package rv_alu_pkg;

    // default datapath width
    localparam int XLEN_DEF = 32;

    // major opcodes handled by the pipeline
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // alu operations, decode to execute
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // r-type layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_s;

    // i-type layout
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_s;

    // one word, read as r-type or i-type depending on opcode
    typedef union packed {
        r_fmt_s      r;
        i_fmt_s      i;
        logic [31:0] raw;
    } instr_u;

endpackage

//--- hw/int_regs.sv
// --------------------
// integer register file
// 31 entries, two write ports, two read ports
// with registered outputs; x0 reads as zero
// --------------------

`timescale 1ns/100ps

module int_regs #(
    parameter int XLEN = 32
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            hold_i,
    // write port a, alu write-back
    input  logic            wreg_a_wr_i,
    input  logic [4:0]      wreg_a_addr_i,
    input  logic [XLEN-1:0] wreg_a_data_i,
    // write port b, load return
    input  logic            wreg_b_wr_i,
    input  logic [4:0]      wreg_b_addr_i,
    input  logic [XLEN-1:0] wreg_b_data_i,
    // read ports
    input  logic            rreg_a_rd_i,
    input  logic [4:0]      rreg_a_addr_i,
    output logic [XLEN-1:0] rreg_a_data_o,
    input  logic            rreg_b_rd_i,
    input  logic [4:0]      rreg_b_addr_i,
    output logic [XLEN-1:0] rreg_b_data_o
);

    // x1..x31, x0 is never stored
    logic [XLEN-1:0] mem [1:31];

    // --------------------
    // storage writes
    // --------------------
    always_ff @(posedge clk_i) begin
        if (!hold_i) begin
            if (wreg_a_wr_i && (wreg_a_addr_i != 5'd0)) begin
                mem[wreg_a_addr_i] <= wreg_a_data_i;
            end
            if (wreg_b_wr_i && (wreg_b_addr_i != 5'd0)) begin
                mem[wreg_b_addr_i] <= wreg_b_data_i;
            end
        end
    end

    // --------------------
    // registered reads
    // --------------------
    // array read sees the value before this edge's writes
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rreg_a_data_o <= '0;
            rreg_b_data_o <= '0;
        end else if (!hold_i) begin
            // outputs keep their value without a strobe
            if (rreg_a_rd_i) begin
                rreg_a_data_o <= (rreg_a_addr_i == 5'd0) ? '0 : mem[rreg_a_addr_i];
            end
            if (rreg_b_rd_i) begin
                rreg_b_data_o <= (rreg_b_addr_i == 5'd0) ? '0 : mem[rreg_b_addr_i];
            end
        end
    end

    // write-back and load return must not collide on one register
    a_no_dual_write : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (!hold_i && wreg_a_wr_i && wreg_b_wr_i && (wreg_a_addr_i != 5'd0))
            |-> (wreg_a_addr_i != wreg_b_addr_i)
    ) else $error("int_regs: both write ports target x%0d", wreg_a_addr_i);

endmodule

//--- hw/alu_decode.sv
// --------------------
// alu decode stage
// splits the instruction word, picks the alu
// operation and immediate, issues register reads
// --------------------

`timescale 1ns/100ps

module alu_decode #(
    parameter int XLEN = 32
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                hold_i,
    input  logic                instr_valid_i,
    input  logic [31:0]         instr_i,
    // register file read requests
    output logic                rd_a_o,
    output logic [4:0]          rs1_o,
    output logic                rd_b_o,
    output logic [4:0]          rs2_o,
    // decoded fields to execute
    output logic                dec_valid_o,
    output rv_alu_pkg::alu_op_e dec_op_o,
    output logic [4:0]          dec_rd_o,
    output logic [4:0]          dec_rs1_o,
    output logic [4:0]          dec_rs2_o,
    output logic                dec_use_imm_o,
    output logic [XLEN-1:0]     dec_imm_o
);

    import rv_alu_pkg::*;

    instr_u          instr;
    logic            is_op;
    logic            is_imm;
    alu_op_e         op_sel;
    logic [XLEN-1:0] imm_sx;

    assign instr  = instr_i;
    assign is_op  = (instr.r.opcode == OPC_OP);
    assign is_imm = (instr.i.opcode == OPC_OP_IMM);

    // sign extend imm[11:0]
    assign imm_sx = {{(XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};

    // --------------------
    // operation select
    // --------------------
    always_comb begin
        op_sel = ALU_ADD;
        case (instr.r.funct3)
            // sub only exists in r-type, addi ignores bit 30
            3'b000: op_sel = (is_op && instr.r.funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001: op_sel = ALU_SLL;
            3'b010: op_sel = ALU_SLT;
            3'b011: op_sel = ALU_SLTU;
            3'b100: op_sel = ALU_XOR;
            // bit 30 picks arithmetic shift in both formats
            3'b101: op_sel = instr.r.funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110: op_sel = ALU_OR;
            3'b111: op_sel = ALU_AND;
        endcase
    end

    // reads start now, data lands with the decoded fields
    assign rd_a_o = instr_valid_i && (is_op || is_imm);
    assign rd_b_o = instr_valid_i && is_op;
    assign rs1_o  = instr.r.rs1;
    assign rs2_o  = instr.r.rs2;

    // --------------------
    // decode register
    // --------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
        end else if (!hold_i) begin
            // unknown opcode becomes a bubble
            dec_valid_o <= rd_a_o;
        end
    end

    // payload, meaningful only with dec_valid_o
    always_ff @(posedge clk_i) begin
        if (!hold_i) begin
            dec_op_o      <= op_sel;
            dec_rd_o      <= instr.r.rd;
            dec_rs1_o     <= instr.r.rs1;
            dec_rs2_o     <= instr.r.rs2;
            dec_use_imm_o <= is_imm;
            dec_imm_o     <= imm_sx;
        end
    end

    a_dec_op_legal : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        dec_valid_o |-> (dec_op_o inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
                                          ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND})
    ) else $error("alu_decode: illegal operation code %0d", dec_op_o);

endmodule

//--- hw/alu_execute.sv
// --------------------
// alu execute stage
// operand forwarding, alu and the result
// register that drives write-back
// --------------------

`timescale 1ns/100ps

module alu_execute #(
    parameter int XLEN = 32
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                hold_i,
    input  logic                dec_valid_i,
    input  rv_alu_pkg::alu_op_e dec_op_i,
    input  logic [4:0]          dec_rd_i,
    input  logic [4:0]          dec_rs1_i,
    input  logic [4:0]          dec_rs2_i,
    input  logic                dec_use_imm_i,
    input  logic [XLEN-1:0]     dec_imm_i,
    // register file read data
    input  logic [XLEN-1:0]     op_a_i,
    input  logic [XLEN-1:0]     op_b_i,
    output logic                res_valid_o,
    output logic [4:0]          res_rd_o,
    output logic [XLEN-1:0]     res_data_o,
    output logic                wb_wr_o
);

    import rv_alu_pkg::*;

    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] opnd_b;
    logic [4:0]      shamt;
    logic [XLEN-1:0] alu_res;
    // copy of the previous port a write
    logic            lw_valid_q;
    logic [4:0]      lw_addr_q;
    logic [XLEN-1:0] lw_data_q;

    // --------------------
    // forwarding
    // --------------------
    // result reg is one ahead, last-write copy two ahead
    always_comb begin
        src_a = op_a_i;
        if ((dec_rs1_i != 5'd0) && wb_wr_o && (res_rd_o == dec_rs1_i)) begin
            src_a = res_data_o;
        end else if ((dec_rs1_i != 5'd0) && lw_valid_q && (lw_addr_q == dec_rs1_i)) begin
            src_a = lw_data_q;
        end
        src_b = op_b_i;
        if ((dec_rs2_i != 5'd0) && wb_wr_o && (res_rd_o == dec_rs2_i)) begin
            src_b = res_data_o;
        end else if ((dec_rs2_i != 5'd0) && lw_valid_q && (lw_addr_q == dec_rs2_i)) begin
            src_b = lw_data_q;
        end
    end

    assign opnd_b = dec_use_imm_i ? dec_imm_i : src_b;
    assign shamt  = opnd_b[4:0];

    // --------------------
    // alu
    // --------------------
    always_comb begin
        case (dec_op_i)
            ALU_ADD:  alu_res = src_a + opnd_b;
            ALU_SUB:  alu_res = src_a - opnd_b;
            ALU_SLL:  alu_res = src_a << shamt;
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(opnd_b)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, src_a < opnd_b};
            ALU_XOR:  alu_res = src_a ^ opnd_b;
            ALU_SRL:  alu_res = src_a >> shamt;
            ALU_SRA:  alu_res = $unsigned($signed(src_a) >>> shamt);
            ALU_OR:   alu_res = src_a | opnd_b;
            ALU_AND:  alu_res = src_a & opnd_b;
            default:  alu_res = '0;
        endcase
    end

    // --------------------
    // result and last-write registers
    // --------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
            wb_wr_o     <= 1'b0;
            lw_valid_q  <= 1'b0;
        end else if (!hold_i) begin
            res_valid_o <= dec_valid_i;
            // x0 target still strobes a result, but no write
            wb_wr_o     <= dec_valid_i && (dec_rd_i != 5'd0);
            // copy lives for one cycle behind the write
            lw_valid_q  <= wb_wr_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!hold_i) begin
            res_rd_o   <= dec_rd_i;
            res_data_o <= alu_res;
            lw_addr_q  <= res_rd_o;
            lw_data_q  <= res_data_o;
        end
    end

    a_no_x0_write : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        wb_wr_o |-> (res_valid_o && (res_rd_o != 5'd0))
    ) else $error("alu_execute: write-back strobe with rd of zero");

endmodule

//--- hw/alu_pipe_top.sv
// --------------------
// alu pipeline top
// decode, register file and execute; result goes
// to write port a, load return to write port b
// --------------------

`timescale 1ns/100ps

module alu_pipe_top #(
    parameter int XLEN = rv_alu_pkg::XLEN_DEF
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            hold_i,
    input  logic            instr_valid_i,
    input  logic [31:0]     instr_i,
    // load return
    input  logic            ld_wr_i,
    input  logic [4:0]      ld_addr_i,
    input  logic [XLEN-1:0] ld_data_i,
    output logic            res_valid_o,
    output logic [4:0]      res_rd_o,
    output logic [XLEN-1:0] res_data_o
);

    import rv_alu_pkg::*;

    // read requests
    logic            rd_a;
    logic [4:0]      rs1;
    logic            rd_b;
    logic [4:0]      rs2;
    // decode to execute
    logic            dec_valid;
    alu_op_e         dec_op;
    logic [4:0]      dec_rd;
    logic [4:0]      dec_rs1;
    logic [4:0]      dec_rs2;
    logic            dec_use_imm;
    logic [XLEN-1:0] dec_imm;
    // operands and write-back
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic            wb_wr;

    alu_decode #(
        .XLEN (XLEN)
    ) u_decode (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .hold_i        (hold_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rd_a_o        (rd_a),
        .rs1_o         (rs1),
        .rd_b_o        (rd_b),
        .rs2_o         (rs2),
        .dec_valid_o   (dec_valid),
        .dec_op_o      (dec_op),
        .dec_rd_o      (dec_rd),
        .dec_rs1_o     (dec_rs1),
        .dec_rs2_o     (dec_rs2),
        .dec_use_imm_o (dec_use_imm),
        .dec_imm_o     (dec_imm)
    );

    int_regs #(
        .XLEN (XLEN)
    ) u_regs (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .hold_i        (hold_i),
        .wreg_a_wr_i   (wb_wr),
        .wreg_a_addr_i (res_rd_o),
        .wreg_a_data_i (res_data_o),
        .wreg_b_wr_i   (ld_wr_i),
        .wreg_b_addr_i (ld_addr_i),
        .wreg_b_data_i (ld_data_i),
        .rreg_a_rd_i   (rd_a),
        .rreg_a_addr_i (rs1),
        .rreg_a_data_o (op_a),
        .rreg_b_rd_i   (rd_b),
        .rreg_b_addr_i (rs2),
        .rreg_b_data_o (op_b)
    );

    alu_execute #(
        .XLEN (XLEN)
    ) u_execute (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .hold_i        (hold_i),
        .dec_valid_i   (dec_valid),
        .dec_op_i      (dec_op),
        .dec_rd_i      (dec_rd),
        .dec_rs1_i     (dec_rs1),
        .dec_rs2_i     (dec_rs2),
        .dec_use_imm_i (dec_use_imm),
        .dec_imm_i     (dec_imm),
        .op_a_i        (op_a),
        .op_b_i        (op_b),
        .res_valid_o   (res_valid_o),
        .res_rd_o      (res_rd_o),
        .res_data_o    (res_data_o),
        .wb_wr_o       (wb_wr)
    );

endmodule

//--- verif/clk_rst_gen.sv
// --------------------
// testbench clock and reset
// free-running clock, active-low reset held
// for a fixed number of cycles
// --------------------

`timescale 1ns/100ps

module clk_rst_gen #(
    parameter real PERIOD_NS    = 10.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // release shortly after an edge, away from sampling
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

//--- verif/alu_pipe_tb.sv
// --------------------
// alu pipeline testbench
// table of directed cycles, then a seeded random mix;
// a register model predicts every result strobe
// --------------------

`timescale 1ns/100ps

module alu_pipe_tb;

    import rv_alu_pkg::*;

    localparam int XLEN        = 32;
    localparam int TABLE_LEN   = 43;
    localparam int RAND_N      = 200;
    localparam int CYCLE_LIMIT = TABLE_LEN + RAND_N + 20;

    logic            clk_i;
    logic            rst_n_i;
    logic            hold_i;
    logic            instr_valid_i;
    logic [31:0]     instr_i;
    logic            ld_wr_i;
    logic [4:0]      ld_addr_i;
    logic [XLEN-1:0] ld_data_i;
    logic            res_valid_o;
    logic [4:0]      res_rd_o;
    logic [XLEN-1:0] res_data_o;

    // --------------------
    // stimulus table
    // --------------------
    string       t_name    [TABLE_LEN];
    logic [31:0] t_instr   [TABLE_LEN];
    logic        t_valid   [TABLE_LEN];
    logic        t_hold    [TABLE_LEN];
    logic        t_ld_wr   [TABLE_LEN];
    logic [4:0]  t_ld_addr [TABLE_LEN];
    logic [31:0] t_ld_data [TABLE_LEN];
    logic        t_known   [TABLE_LEN];
    logic [31:0] t_exp     [TABLE_LEN];
    int          n_rows;

    // row currently on the inputs
    string       cur_name;
    logic        cur_known;
    logic [31:0] cur_exp;

    // reference model and expected results
    logic [31:0] model_regs [32];
    string       q_name  [$];
    logic [4:0]  q_rd    [$];
    logic [31:0] q_data  [$];
    logic        q_known [$];
    logic [31:0] q_hand  [$];
    int          q_tag   [$];
    int          adv_cnt;
    int          cycle_cnt;

    clk_rst_gen #(
        .PERIOD_NS    (10.0),
        .RESET_CYCLES (3)
    ) u_clk_rst (
        .clk_o   (clk_i),
        .rst_n_o (rst_n_i)
    );

    alu_pipe_top #(
        .XLEN (XLEN)
    ) DUT (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .hold_i        (hold_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .ld_wr_i       (ld_wr_i),
        .ld_addr_i     (ld_addr_i),
        .ld_data_i     (ld_data_i),
        .res_valid_o   (res_valid_o),
        .res_rd_o      (res_rd_o),
        .res_data_o    (res_data_o)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // --------------------
    // instruction builders
    // --------------------
    function automatic logic [31:0] build_r(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        instr_u w;
        w.r.funct7 = f7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = f3;
        w.r.rd     = rd;
        w.r.opcode = OPC_OP;
        return w.raw;
    endfunction

    function automatic logic [31:0] build_i(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd);
        instr_u w;
        w.i.imm12  = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = f3;
        w.i.rd     = rd;
        w.i.opcode = OPC_OP_IMM;
        return w.raw;
    endfunction

    // isa result of one op/op-imm word
    function automatic logic [31:0] isa_result(input logic [31:0] word, input logic [31:0] a,
                                               input logic [31:0] b_reg);
        instr_u      w;
        logic        is_r;
        logic [31:0] b;
        logic [4:0]  sh;
        w.raw = word;
        is_r  = (w.r.opcode == OPC_OP);
        b     = is_r ? b_reg : {{20{w.i.imm12[11]}}, w.i.imm12};
        sh    = b[4:0];
        case (w.r.funct3)
            3'd0: return (is_r && w.r.funct7[5]) ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            // bit 30 means arithmetic in both formats
            3'd5: return w.r.funct7[5] ? 32'($signed(a) >>> sh) : a >> sh;
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic add_row(input string name, input logic [31:0] word, input logic valid,
                           input logic hold, input logic ld, input logic [4:0] la,
                           input logic [31:0] ldd, input logic known, input logic [31:0] exp);
        t_name[n_rows]    = name;
        t_instr[n_rows]   = word;
        t_valid[n_rows]   = valid;
        t_hold[n_rows]    = hold;
        t_ld_wr[n_rows]   = ld;
        t_ld_addr[n_rows] = la;
        t_ld_data[n_rows] = ldd;
        t_known[n_rows]   = known;
        t_exp[n_rows]     = exp;
        n_rows++;
    endtask

    task automatic add_instr(input string name, input logic [31:0] word,
                             input logic [31:0] exp);
        add_row(name, word, 1'b1, 1'b0, 1'b0, 5'd0, 32'd0, 1'b1, exp);
    endtask

    task automatic add_load(input string name, input logic [4:0] la, input logic [31:0] ldd);
        add_row(name, 32'd0, 1'b0, 1'b0, 1'b1, la, ldd, 1'b0, 32'd0);
    endtask

    task automatic add_idle(input string name, input logic hold);
        add_row(name, 32'd0, 1'b0, hold, 1'b0, 5'd0, 32'd0, 1'b0, 32'd0);
    endtask

    task automatic build_table();
        n_rows = 0;
        // operand setup through the load port
        add_load("load_x1", 5'd1, 32'h0000_0005);
        add_load("load_x2", 5'd2, 32'hFFFF_FFFD);
        add_load("load_x3", 5'd3, 32'h8000_0000);
        add_load("load_x4", 5'd4, 32'h0000_0003);
        add_load("load_x5", 5'd5, 32'h0000_FFFF);
        // r-type set
        add_instr("add",  build_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd10), 32'h0000_0002);
        add_instr("sub",  build_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd11), 32'h0000_0008);
        add_instr("sll",  build_r(7'h00, 5'd4, 5'd2, 3'd1, 5'd12), 32'hFFFF_FFE8);
        add_instr("slt",  build_r(7'h00, 5'd1, 5'd2, 3'd2, 5'd13), 32'h0000_0001);
        add_instr("sltu", build_r(7'h00, 5'd1, 5'd2, 3'd3, 5'd14), 32'h0000_0000);
        add_instr("xor",  build_r(7'h00, 5'd5, 5'd2, 3'd4, 5'd15), 32'hFFFF_0002);
        add_instr("srl",  build_r(7'h00, 5'd4, 5'd3, 3'd5, 5'd16), 32'h1000_0000);
        add_instr("sra",  build_r(7'h20, 5'd4, 5'd3, 3'd5, 5'd17), 32'hF000_0000);
        add_instr("or",   build_r(7'h00, 5'd5, 5'd1, 3'd6, 5'd18), 32'h0000_FFFF);
        add_instr("and",  build_r(7'h00, 5'd5, 5'd2, 3'd7, 5'd19), 32'h0000_FFFD);
        // i-type with negative immediates
        add_instr("addi",  build_i(12'hFF9, 5'd1, 3'd0, 5'd20), 32'hFFFF_FFFE);
        add_instr("slti",  build_i(12'hFFF, 5'd2, 3'd2, 5'd21), 32'h0000_0001);
        add_instr("sltiu", build_i(12'hFFF, 5'd1, 3'd3, 5'd22), 32'h0000_0001);
        add_instr("xori",  build_i(12'hFFF, 5'd1, 3'd4, 5'd23), 32'hFFFF_FFFA);
        add_instr("ori",   build_i(12'hFF0, 5'd4, 3'd6, 5'd24), 32'hFFFF_FFF3);
        add_instr("andi",  build_i(12'h0F0, 5'd2, 3'd7, 5'd25), 32'h0000_00F0);
        add_instr("srai",  build_i(12'h401, 5'd2, 3'd5, 5'd26), 32'hFFFF_FFFE);
        add_instr("srli",  build_i(12'h001, 5'd2, 3'd5, 5'd27), 32'h7FFF_FFFE);
        add_instr("slli",  build_i(12'h004, 5'd2, 3'd1, 5'd28), 32'hFFFF_FFD0);
        // dependent chains at distance 1 and 2
        add_instr("fwd_base", build_i(12'h00A, 5'd1, 3'd0, 5'd6), 32'd15);
        add_instr("fwd_d1",   build_r(7'h00, 5'd1, 5'd6, 3'd0, 5'd7), 32'd20);
        add_instr("fwd_d1_d2", build_r(7'h00, 5'd7, 5'd6, 3'd0, 5'd8), 32'd35);
        add_instr("fwd_d1_rf", build_r(7'h20, 5'd6, 5'd8, 3'd0, 5'd9), 32'd20);
        add_idle("gap", 1'b0);
        add_instr("fwd_d2", build_i(12'h001, 5'd9, 3'd0, 5'd30), 32'd21);
        // x0 target and bubble
        add_instr("x0_write",  build_i(12'h064, 5'd1, 3'd0, 5'd0), 32'd105);
        add_instr("x0_read",   build_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd31), 32'd5);
        add_row("bad_opcode", 32'h0000_006F, 1'b1, 1'b0, 1'b0, 5'd0, 32'd0, 1'b0, 32'd0);
        add_instr("x0_x0",     build_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd29), 32'd0);
        // hold with two in flight
        add_instr("hold_a", build_i(12'h001, 5'd4, 3'd0, 5'd6), 32'd4);
        add_instr("hold_b", build_i(12'h002, 5'd6, 3'd0, 5'd7), 32'd6);
        add_idle("hold_1", 1'b1);
        // word offered while held is ignored
        add_row("hold_2", build_i(12'h001, 5'd1, 3'd0, 5'd9), 1'b1, 1'b1, 1'b0, 5'd0,
                32'd0, 1'b0, 32'd0);
        add_idle("hold_3", 1'b1);
        add_idle("hold_4", 1'b1);
        add_instr("after_hold", build_r(7'h00, 5'd7, 5'd6, 3'd0, 5'd8), 32'd10);
        add_idle("tail_1", 1'b0);
        add_idle("tail_2", 1'b0);
    endtask

    // random supported word with rd in x0 or x6..x15 and sources in x0..x15
    function automatic logic [31:0] random_instr();
        logic [31:0] rnd;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [11:0] imm;
        rnd = $urandom;
        rd  = (rnd[3:0] > 4'd10 || rnd[3:0] == 4'd0) ? 5'd0 : 5'(rnd[3:0] + 4'd5);
        f3  = rnd[6:4];
        if (rnd[7]) begin
            return build_r((f3 == 3'd0 || f3 == 3'd5) ? {1'b0, rnd[8], 5'd0} : 7'h00,
                           {1'b0, rnd[12:9]}, {1'b0, rnd[16:13]}, f3, rd);
        end
        imm = rnd[28:17];
        if (f3 == 3'd1) begin
            imm = {7'd0, rnd[21:17]};
        end else if (f3 == 3'd5) begin
            imm = {1'b0, rnd[8], 5'd0, rnd[21:17]};
        end
        return build_i(imm, {1'b0, rnd[12:9]}, f3, rd);
    endfunction

    // --------------------
    // result check and model update
    // --------------------
    // inputs and outputs are both settled at mid-cycle
    always @(negedge clk_i) begin
        instr_u w;
        logic [31:0] res;
        if (rst_n_i) begin
            if (res_valid_o && !hold_i) begin
                assert (q_rd.size() > 0)
                    else report_failure("result strobe with no instruction outstanding");
                assert (res_rd_o == q_rd[0])
                    else report_failure($sformatf("error: %s rd expected %0d actual %0d",
                                        q_name[0], q_rd[0], res_rd_o));
                assert (res_data_o == q_data[0])
                    else report_failure($sformatf("error: %s expected %h actual %h",
                                        q_name[0], q_data[0], res_data_o));
                assert (!q_known[0] || res_data_o == q_hand[0])
                    else report_failure($sformatf("error: %s expected %h actual %h",
                                        q_name[0], q_hand[0], res_data_o));
                assert (adv_cnt == q_tag[0] + 2)
                    else report_failure($sformatf("result of %s arrived at the wrong cycle",
                                        q_name[0]));
                void'(q_name.pop_front());
                void'(q_rd.pop_front());
                void'(q_data.pop_front());
                void'(q_known.pop_front());
                void'(q_hand.pop_front());
                void'(q_tag.pop_front());
            end
            w.raw = instr_i;
            if (instr_valid_i && !hold_i &&
                (w.r.opcode == OPC_OP || w.r.opcode == OPC_OP_IMM)) begin
                res = isa_result(instr_i, model_regs[w.r.rs1], model_regs[w.r.rs2]);
                q_name.push_back(cur_name);
                q_rd.push_back(w.r.rd);
                q_data.push_back(res);
                q_known.push_back(cur_known);
                q_hand.push_back(cur_exp);
                q_tag.push_back(adv_cnt);
                if (w.r.rd != 5'd0) begin
                    model_regs[w.r.rd] = res;
                end
            end
            // load lands after same-cycle reads
            if (ld_wr_i && !hold_i && ld_addr_i != 5'd0) begin
                model_regs[ld_addr_i] = ld_data_i;
            end
            if (!hold_i) begin
                adv_cnt++;
            end
        end
    end

    always @(posedge clk_i) begin
        if (rst_n_i) begin
            cycle_cnt++;
            if (cycle_cnt > CYCLE_LIMIT) begin
                report_failure("timeout: run exceeded its cycle limit");
            end
        end
    end

    // --------------------
    // stimulus
    // --------------------
    initial begin
        logic [31:0] rnd;
        hold_i        = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        ld_wr_i       = 1'b0;
        ld_addr_i     = '0;
        ld_data_i     = '0;
        cur_name      = "reset";
        cur_known     = 1'b0;
        cur_exp       = '0;
        adv_cnt       = 0;
        cycle_cnt     = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        void'($urandom(46982));
        build_table();
        assert (n_rows == TABLE_LEN) else report_failure("stimulus table has wrong length");

        wait (rst_n_i === 1'b1);
        for (int k = 0; k < TABLE_LEN; k++) begin
            @(posedge clk_i);
            #1;
            cur_name      = t_name[k];
            cur_known     = t_known[k];
            cur_exp       = t_exp[k];
            instr_valid_i = t_valid[k];
            instr_i       = t_instr[k];
            hold_i        = t_hold[k];
            ld_wr_i       = t_ld_wr[k];
            ld_addr_i     = t_ld_addr[k];
            ld_data_i     = t_ld_data[k];
        end

        // random mix with loads only to x1..x5
        for (int k = 0; k < RAND_N; k++) begin
            @(posedge clk_i);
            #1;
            rnd           = $urandom;
            cur_name      = $sformatf("random_%0d", k);
            cur_known     = 1'b0;
            hold_i        = (rnd[7:4] == 4'd0);
            instr_valid_i = (rnd[2:0] >= 3'd2);
            instr_i       = random_instr();
            ld_wr_i       = (rnd[2:0] == 3'd1);
            ld_addr_i     = 5'(32'd1 + (32'(rnd[10:8]) % 32'd5));
            ld_data_i     = $urandom;
        end

        @(posedge clk_i);
        #1;
        cur_name      = "drain";
        hold_i        = 1'b0;
        instr_valid_i = 1'b0;
        ld_wr_i       = 1'b0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        #1;
        assert (q_rd.size() == 0)
            else report_failure("results still outstanding after the drain cycles");
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- tb.f
hw/rv_alu_pkg.sv
hw/int_regs.sv
hw/alu_decode.sv
hw/alu_execute.sv
hw/alu_pipe_top.sv
verif/clk_rst_gen.sv
verif/alu_pipe_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the alu pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f --top-module alu_pipe_tb \
    -Mdir obj_dir -o sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
sim_status=$?

if grep -q "Simulation failed" sim.log; then
    echo "FAIL (see sim.log)"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

if ! grep -q "Simulation completed successfully" sim.log; then
    echo "no pass line in sim.log"
    exit 1
fi

echo "PASS"
exit 0
